// File: files.f
source/rv_isa_pkg.sv
source/pipe_ctrl_pkg.sv
source/decode_control.sv
source/alu_control.sv
source/branch_controller.sv
source/forwarding_unit.sv
source/pipeline_controller.sv
source/control_unit.sv
bench/tb_clock.sv
bench/tb_control_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_control_unit
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
LINTFLAGS ?= --lint-only --timing
SIMFLAGS  ?= --binary --timing -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIMFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '*** PASSED ***' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_control_unit;

  import rv_isa_pkg::*;
  import pipe_ctrl_pkg::*;

  // the directed tests take a few hundred cycles
  localparam int MAX_CYCLES = 2000;

  // expected {pc_en, en, clr} for each row of the stage table
  localparam logic [8:0] STG_RESET  = {1'b0, 4'b0000, 4'b1111};
  localparam logic [8:0] STG_FREEZE = {1'b0, 4'b0000, 4'b0000};
  localparam logic [8:0] STG_BRANCH = {1'b1, 4'b1111, 4'b0111};
  localparam logic [8:0] STG_LOAD   = {1'b0, 4'b1110, 4'b0010};
  localparam logic [8:0] STG_RUN    = {1'b1, 4'b1111, 4'b0000};

  logic clk;
  logic rst_n;
  opcode_t opcode_id;
  fun7_t fun7_exe;
  fun3_t fun3_exe;
  alu_op_t alu_op_exe;
  fun3_t fun3_mem;
  logic zero_mem, jump_mem, branch_mem;
  logic mret_type, interrupt, divide_stall, stall_pipl;
  reg_idx_t rs1_id, rs2_id, rs1_exe, rs2_exe, rs2_mem, rd_exe, rd_mem, rd_wb;
  logic reg_write_mem, reg_write_wb, mem_to_reg_exe, csr_type_exe;
  id_ctrl_t id_ctrl;
  logic invalid_inst;
  alu_t alu_ctrl_exe;
  logic m_type_exe, divide_instruction, pc_sel_mem;
  fwd_t fwd;
  stage_ctrl_t stage;

  logic [31:0] lfsr_state = 32'hf267;
  int cycles = 0;

  tb_clock clock_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  control_unit UUT (.*);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $fatal(1, "simulation timed out");
    end
  end

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [4:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[3:0], lfsr_state[0]};
    end
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
      $display("*** FAILED ***");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic init_inputs();
    opcode_id <= OP_IMM;
    fun7_exe <= '0;
    fun3_exe <= '0;
    alu_op_exe <= ALU_OP_ADD;
    fun3_mem <= '0;
    zero_mem <= 1'b0;
    jump_mem <= 1'b0;
    branch_mem <= 1'b0;
    mret_type <= 1'b0;
    interrupt <= 1'b0;
    divide_stall <= 1'b0;
    stall_pipl <= 1'b0;
    rs1_id <= '0;
    rs2_id <= '0;
    rs1_exe <= '0;
    rs2_exe <= '0;
    rs2_mem <= '0;
    rd_exe <= '0;
    rd_mem <= '0;
    rd_wb <= '0;
    reg_write_mem <= 1'b0;
    reg_write_wb <= 1'b0;
    mem_to_reg_exe <= 1'b0;
    csr_type_exe <= 1'b0;
  endtask

  task automatic reset_test();
    @(negedge clk);
    check("reset stage", 32'(STG_RESET), 32'(stage));
    check("reset invalid", 32'd0, 32'(invalid_inst));
    wait (rst_n === 1'b1);
    @(negedge clk);
    check("after reset stage", 32'(STG_RUN), 32'(stage));
    check("after reset invalid", 32'd0, 32'(invalid_inst));
  endtask

  task automatic decode_test(input string name, input opcode_t op);
    id_ctrl_t exp;
    logic lui, auipc, jal, jalr, br, ld, st, imm, rr, sys;
    lui = (op == OP_LUI);
    auipc = (op == OP_AUIPC);
    jal = (op == OP_JAL);
    jalr = (op == OP_JALR);
    br = (op == OP_BRANCH);
    ld = (op == OP_LOAD);
    st = (op == OP_STORE);
    imm = (op == OP_IMM);
    rr = (op == OP_REG);
    sys = (op == OP_SYSTEM);
    exp.reg_write = !(br || st);
    exp.mem_write = st;
    exp.mem_to_reg = ld ? WB_MEM : (jal || jalr) ? WB_PC4 : sys ? WB_CSR : WB_ALU;
    exp.branch = br;
    // operand b comes from the immediate
    exp.alu_src = lui || auipc || jalr || ld || st || imm;
    exp.jump = jal || jalr;
    exp.lui = lui;
    exp.auipc = auipc;
    exp.jal = jal;
    exp.alu_op = br ? ALU_OP_BRANCH : rr ? ALU_OP_R : imm ? ALU_OP_I : ALU_OP_ADD;
    exp.csr_type = sys;
    exp.use_rs1 = !(lui || auipc || jal);
    exp.use_rs2 = rr || br || st;
    @(posedge clk);
    opcode_id <= op;
    @(negedge clk);
    check(name, 32'(exp), 32'(id_ctrl));
  endtask

  task automatic drive_clear(input int src, input logic value);
    case (src)
      0: interrupt <= value;
      1: mret_type <= value;
      default: jump_mem <= value;
    endcase
  endtask

  task automatic raise_invalid();
    @(posedge clk);
    opcode_id <= 7'b0000000;
    @(negedge clk);
    check("illegal ctrl", 32'd0, 32'(id_ctrl));
    @(posedge clk);
    opcode_id <= OP_REG;
    @(negedge clk);
    check("illegal raised", 32'd1, 32'(invalid_inst));
    @(posedge clk);
    @(negedge clk);
    check("illegal held", 32'd1, 32'(invalid_inst));
  endtask

  task automatic illegal_test();
    string src_name [3];
    src_name = '{"interrupt", "mret", "jump"};
    for (int s = 0; s < 3; s++) begin
      raise_invalid();
      @(posedge clk);
      drive_clear(s, 1'b1);
      @(posedge clk);
      drive_clear(s, 1'b0);
      @(negedge clk);
      check({"clear by ", src_name[s]}, 32'd0, 32'(invalid_inst));
    end
    // set and clear on the same edge
    @(posedge clk);
    opcode_id <= 7'b0000000;
    drive_clear(0, 1'b1);
    @(posedge clk);
    opcode_id <= OP_REG;
    drive_clear(0, 1'b0);
    @(negedge clk);
    check("clear wins", 32'd0, 32'(invalid_inst));
  endtask

  task automatic alu_test();
    alu_t base_tbl [8];
    alu_t mdiv_tbl [8];
    fun7_t f7_list [3];
    alu_op_t op;
    fun3_t f3;
    alu_t op_exp;
    logic m_exp;
    logic div_exp;
    base_tbl = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
    mdiv_tbl = '{MUL, MULH, MULHSU, MULHU, DIV_OP, DIV_OP, REM_OP, REM_OP};
    f7_list = '{7'h00, 7'h20, 7'h01};
    for (int a = 0; a < 4; a++) begin
      for (int f = 0; f < 8; f++) begin
        for (int s = 0; s < 3; s++) begin
          op = alu_op_t'(a);
          f3 = fun3_t'(f);
          // funct3 010 and 011 are not branches
          if (op == ALU_OP_BRANCH && f3[2:1] == 2'b01) continue;
          m_exp = (op == ALU_OP_R) && (f7_list[s] == 7'h01);
          div_exp = m_exp && f3[2];
          if (op == ALU_OP_ADD) begin
            op_exp = ADD;
          end else if (op == ALU_OP_BRANCH) begin
            op_exp = f3[2] ? (f3[1] ? SLTU : SLT) : SUB;
          end else if (m_exp) begin
            op_exp = mdiv_tbl[f];
          end else begin
            op_exp = base_tbl[f];
            if (f7_list[s][5] && f3 == 3'b101) op_exp = SRA;
            if (f7_list[s][5] && f3 == 3'b000 && op == ALU_OP_R) op_exp = SUB;
          end
          @(posedge clk);
          alu_op_exe <= op;
          fun3_exe <= f3;
          fun7_exe <= f7_list[s];
          @(negedge clk);
          check($sformatf("alu op%0d f3=%0d f7=%h", a, f, f7_list[s]),
                32'({op_exp, m_exp, div_exp}),
                32'({alu_ctrl_exe, m_type_exe, divide_instruction}));
        end
      end
    end
  endtask

  task automatic branch_case(input string name, input fun3_t f3, input logic br,
                             input logic jmp, input logic zero, input logic taken);
    @(posedge clk);
    fun3_mem <= f3;
    branch_mem <= br;
    jump_mem <= jmp;
    zero_mem <= zero;
    @(negedge clk);
    check(name, 32'(taken), 32'(pc_sel_mem));
    check({name, " stage"}, 32'(taken ? STG_BRANCH : STG_RUN), 32'(stage));
  endtask

  task automatic branch_test();
    branch_t conds [6];
    logic zb;
    logic taken;
    conds = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
    for (int c = 0; c < 6; c++) begin
      for (int z = 0; z < 2; z++) begin
        zb = z[0];
        // bit 2 selects a less-than compare, bit 0 inverts the outcome
        taken = conds[c][0] ^ (conds[c][2] ? !zb : zb);
        branch_case($sformatf("branch f3=%b zero=%0d", conds[c], z),
                    conds[c], 1'b1, 1'b0, zb, taken);
      end
    end
    branch_case("jump", 3'b000, 1'b0, 1'b1, 1'b0, 1'b1);
    branch_case("no branch", 3'b001, 1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  function automatic logic writes_reg(input logic we, input reg_idx_t rd, input reg_idx_t rs);
    return we && (rd != 5'd0) && (rd == rs);
  endfunction

  task automatic forwarding_test(input int rounds);
    reg_idx_t idx [7];
    logic [4:0] bits;
    logic mem_we;
    logic wb_we;
    fwd_t exp;
    for (int r = 0; r < rounds; r++) begin
      // two bits per index keep matches and x0 frequent
      for (int k = 0; k < 7; k++) begin
        take_bits(2, bits);
        idx[k] = bits;
      end
      take_bits(1, bits);
      mem_we = bits[0];
      take_bits(1, bits);
      wb_we = bits[0];
      exp.rd1_id = writes_reg(wb_we, idx[6], idx[0]);
      exp.rd2_id = writes_reg(wb_we, idx[6], idx[1]);
      exp.rd1_exe = writes_reg(mem_we, idx[5], idx[2]) ? FWD_MEM :
                    writes_reg(wb_we, idx[6], idx[2]) ? FWD_WB : FWD_NONE;
      exp.rd2_exe = writes_reg(mem_we, idx[5], idx[3]) ? FWD_MEM :
                    writes_reg(wb_we, idx[6], idx[3]) ? FWD_WB : FWD_NONE;
      exp.rd2_mem = writes_reg(wb_we, idx[6], idx[4]);
      @(posedge clk);
      rs1_id <= idx[0];
      rs2_id <= idx[1];
      rs1_exe <= idx[2];
      rs2_exe <= idx[3];
      rs2_mem <= idx[4];
      rd_mem <= idx[5];
      rd_wb <= idx[6];
      reg_write_mem <= mem_we;
      reg_write_wb <= wb_we;
      @(negedge clk);
      check($sformatf("forwarding round %0d", r), 32'(exp), 32'(fwd));
    end
  endtask

  // late is {csr, load} in EXE, ctl is {jump, stall, divide}
  task automatic stage_case(input string name, input opcode_t op, input reg_idx_t rs1,
                            input reg_idx_t rs2, input reg_idx_t rd, input logic [1:0] late,
                            input logic [2:0] ctl, input logic [8:0] expected);
    @(posedge clk);
    opcode_id <= op;
    rs1_id <= rs1;
    rs2_id <= rs2;
    rd_exe <= rd;
    csr_type_exe <= late[1];
    mem_to_reg_exe <= late[0];
    jump_mem <= ctl[2];
    stall_pipl <= ctl[1];
    divide_stall <= ctl[0];
    @(negedge clk);
    check(name, 32'(expected), 32'(stage));
  endtask

  task automatic stage_test();
    stage_case("load rs1", OP_REG, 5'd5, 5'd9, 5'd5, 2'b01, 3'b000, STG_LOAD);
    stage_case("load rs2", OP_REG, 5'd9, 5'd5, 5'd5, 2'b01, 3'b000, STG_LOAD);
    stage_case("csr rs1", OP_IMM, 5'd7, 5'd0, 5'd7, 2'b10, 3'b000, STG_LOAD);
    stage_case("unused rs2", OP_IMM, 5'd9, 5'd5, 5'd5, 2'b01, 3'b000, STG_RUN);
    stage_case("lui no source", OP_LUI, 5'd5, 5'd5, 5'd5, 2'b01, 3'b000, STG_RUN);
    stage_case("rd zero", OP_REG, 5'd0, 5'd0, 5'd0, 2'b01, 3'b000, STG_RUN);
    stage_case("no late result", OP_REG, 5'd5, 5'd5, 5'd5, 2'b00, 3'b000, STG_RUN);
    stage_case("branch over load", OP_REG, 5'd5, 5'd9, 5'd5, 2'b01, 3'b100, STG_BRANCH);
    stage_case("stall over branch", OP_REG, 5'd5, 5'd9, 5'd5, 2'b01, 3'b110, STG_FREEZE);
    stage_case("divide over branch", OP_REG, 5'd5, 5'd9, 5'd5, 2'b01, 3'b101, STG_FREEZE);
    stage_case("idle", OP_IMM, 5'd0, 5'd0, 5'd0, 2'b00, 3'b000, STG_RUN);
  endtask

  initial begin
    init_inputs();
    reset_test();
    decode_test("decode lui", OP_LUI);
    decode_test("decode auipc", OP_AUIPC);
    decode_test("decode jal", OP_JAL);
    decode_test("decode jalr", OP_JALR);
    decode_test("decode branch", OP_BRANCH);
    decode_test("decode load", OP_LOAD);
    decode_test("decode store", OP_STORE);
    decode_test("decode imm", OP_IMM);
    decode_test("decode reg", OP_REG);
    decode_test("decode system", OP_SYSTEM);
    illegal_test();
    alu_test();
    branch_test();
    forwarding_test(40);
    stage_test();
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release on a rising edge so the first active cycle is a full one
  initial begin
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: source/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
  input  logic                       clk,
  input  logic                       rst_n,
  input  rv_isa_pkg::opcode_t        opcode_id,
  input  rv_isa_pkg::fun7_t          fun7_exe,
  input  rv_isa_pkg::fun3_t          fun3_exe,
  input  rv_isa_pkg::alu_op_t        alu_op_exe,
  input  rv_isa_pkg::fun3_t          fun3_mem,
  input  logic                       zero_mem,
  input  logic                       jump_mem,
  input  logic                       branch_mem,
  input  logic                       mret_type,
  input  logic                       interrupt,
  input  logic                       divide_stall,
  input  logic                       stall_pipl,
  input  rv_isa_pkg::reg_idx_t       rs1_id,
  input  rv_isa_pkg::reg_idx_t       rs2_id,
  input  rv_isa_pkg::reg_idx_t       rs1_exe,
  input  rv_isa_pkg::reg_idx_t       rs2_exe,
  input  rv_isa_pkg::reg_idx_t       rs2_mem,
  input  rv_isa_pkg::reg_idx_t       rd_exe,
  input  rv_isa_pkg::reg_idx_t       rd_mem,
  input  rv_isa_pkg::reg_idx_t       rd_wb,
  input  logic                       reg_write_mem,
  input  logic                       reg_write_wb,
  input  logic                       mem_to_reg_exe,
  input  logic                       csr_type_exe,
  output pipe_ctrl_pkg::id_ctrl_t    id_ctrl,
  output logic                       invalid_inst,
  output rv_isa_pkg::alu_t           alu_ctrl_exe,
  output logic                       m_type_exe,
  output logic                       divide_instruction,
  output logic                       pc_sel_mem,
  output pipe_ctrl_pkg::fwd_t        fwd,
  output pipe_ctrl_pkg::stage_ctrl_t stage
);

  import rv_isa_pkg::*;

  // any redirect or trap return drops the illegal flag
  logic clear_invalid;
  assign clear_invalid = pc_sel_mem | interrupt | mret_type;

  decode_control dec_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .opcode       (opcode_id),
    .clear_invalid(clear_invalid),
    .ctrl         (id_ctrl),
    .invalid_inst (invalid_inst)
  );

  alu_control alu_ctrl_inst (
    .fun3              (fun3_exe),
    .fun7              (fun7_exe),
    .alu_op            (alu_op_exe),
    .alu_ctrl          (alu_ctrl_exe),
    .m_type            (m_type_exe),
    .divide_instruction(divide_instruction)
  );

  branch_controller branch_ctrl_inst (
    .fun3  (branch_t'(fun3_mem)),
    .branch(branch_mem),
    .jump  (jump_mem),
    .zero  (zero_mem),
    .pc_sel(pc_sel_mem)
  );

  forwarding_unit fwd_unit_inst (
    .rs1_id       (rs1_id),
    .rs2_id       (rs2_id),
    .rs1_exe      (rs1_exe),
    .rs2_exe      (rs2_exe),
    .rs2_mem      (rs2_mem),
    .rd_mem       (rd_mem),
    .rd_wb        (rd_wb),
    .reg_write_mem(reg_write_mem),
    .reg_write_wb (reg_write_wb),
    .fwd          (fwd)
  );

  pipeline_controller pipe_ctrl_inst (
    .rst_n         (rst_n),
    .rs1_id        (rs1_id),
    .rs2_id        (rs2_id),
    .use_rs1       (id_ctrl.use_rs1),
    .use_rs2       (id_ctrl.use_rs2),
    .rd_exe        (rd_exe),
    .mem_to_reg_exe(mem_to_reg_exe),
    .csr_type_exe  (csr_type_exe),
    .pc_sel_mem    (pc_sel_mem),
    .stall_pipl    (stall_pipl),
    .divide_stall  (divide_stall),
    .stage         (stage)
  );

endmodule

`default_nettype wire

// File: source/pipeline_controller.sv
`timescale 1ns/1ps
`default_nettype none

module pipeline_controller (
  input  logic                       rst_n,
  input  rv_isa_pkg::reg_idx_t       rs1_id,
  input  rv_isa_pkg::reg_idx_t       rs2_id,
  input  logic                       use_rs1,
  input  logic                       use_rs2,
  input  rv_isa_pkg::reg_idx_t       rd_exe,
  input  logic                       mem_to_reg_exe,
  input  logic                       csr_type_exe,
  input  logic                       pc_sel_mem,
  input  logic                       stall_pipl,
  input  logic                       divide_stall,
  output pipe_ctrl_pkg::stage_ctrl_t stage
);

  import pipe_ctrl_pkg::*;

  logic late_result_exe;
  logic src_match;
  logic load_hazard;
  logic freeze;

  // load and CSR results are not ready before MEM
  assign late_result_exe = mem_to_reg_exe | csr_type_exe;
  assign src_match = (use_rs1 && (rd_exe == rs1_id)) || (use_rs2 && (rd_exe == rs2_id));
  assign load_hazard = late_result_exe && (rd_exe != '0) && src_match;
  assign freeze = stall_pipl | divide_stall;

  always_comb begin
    stage.pc_en = 1'b1;
    stage.en = '1;
    stage.clr = '0;
    if (!rst_n) begin
      stage.pc_en = 1'b0;
      stage.en = '0;
      stage.clr = '1;
    end else if (freeze) begin
      // everything in flight holds its place
      stage.pc_en = 1'b0;
      stage.en = '0;
    end else if (pc_sel_mem) begin
      // flush the three younger instructions
      stage.clr[IF_ID] = 1'b1;
      stage.clr[ID_EXE] = 1'b1;
      stage.clr[EXE_MEM] = 1'b1;
    end else if (load_hazard) begin
      // hold PC and IF/ID, insert a bubble into EXE
      stage.pc_en = 1'b0;
      stage.en[IF_ID] = 1'b0;
      stage.clr[ID_EXE] = 1'b1;
    end
  end

  always_comb begin
    a_clr_needs_en: assert final (!rst_n || ((stage.clr & ~stage.en) == '0))
      else $error("clear without enable: en=%b clr=%b", stage.en, stage.clr);
  end

endmodule

`default_nettype wire

// File: source/forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit (
  input  rv_isa_pkg::reg_idx_t rs1_id,
  input  rv_isa_pkg::reg_idx_t rs2_id,
  input  rv_isa_pkg::reg_idx_t rs1_exe,
  input  rv_isa_pkg::reg_idx_t rs2_exe,
  input  rv_isa_pkg::reg_idx_t rs2_mem,
  input  rv_isa_pkg::reg_idx_t rd_mem,
  input  rv_isa_pkg::reg_idx_t rd_wb,
  input  logic                 reg_write_mem,
  input  logic                 reg_write_wb,
  output pipe_ctrl_pkg::fwd_t  fwd
);

  import rv_isa_pkg::*;
  import pipe_ctrl_pkg::*;

  // x0 is never a forwarding source
  function automatic logic hit(input logic wr, input reg_idx_t rd, input reg_idx_t rs);
    return wr && (rd != '0) && (rd == rs);
  endfunction

  // the younger MEM result has priority over WB
  function automatic fwd_sel_t exe_sel(input logic mem_hit, input logic wb_hit);
    if (mem_hit) begin
      return FWD_MEM;
    end else if (wb_hit) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  always_comb begin
    // register file bypass in ID
    fwd.rd1_id = hit(reg_write_wb, rd_wb, rs1_id);
    fwd.rd2_id = hit(reg_write_wb, rd_wb, rs2_id);
    fwd.rd1_exe = exe_sel(hit(reg_write_mem, rd_mem, rs1_exe),
                          hit(reg_write_wb, rd_wb, rs1_exe));
    fwd.rd2_exe = exe_sel(hit(reg_write_mem, rd_mem, rs2_exe),
                          hit(reg_write_wb, rd_wb, rs2_exe));
    // store data for a load followed by a store
    fwd.rd2_mem = hit(reg_write_wb, rd_wb, rs2_mem);
  end

endmodule

`default_nettype wire

// File: source/branch_controller.sv
`timescale 1ns/1ps
`default_nettype none

module branch_controller (
  input  rv_isa_pkg::branch_t fun3,
  input  logic                branch,
  input  logic                jump,
  input  logic                zero,
  output logic                pc_sel
);

  import rv_isa_pkg::*;

  logic cond_met;

  // SLT and SLTU leave zero when the less-than test fails
  always_comb begin
    unique case (fun3)
      BEQ, BGE, BGEU: cond_met = zero;
      BNE, BLT, BLTU: cond_met = !zero;
      default:        cond_met = 1'b0;
    endcase
  end

  assign pc_sel = jump | (branch & cond_met);

  always_comb begin
    a_branch_fun3: assert final (!branch || (fun3 != 3'b010 && fun3 != 3'b011))
      else $error("branch with reserved funct3 %b", fun3);
  end

endmodule

`default_nettype wire

// File: source/alu_control.sv
`timescale 1ns/1ps
`default_nettype none

module alu_control (
  input  rv_isa_pkg::fun3_t   fun3,
  input  rv_isa_pkg::fun7_t   fun7,
  input  rv_isa_pkg::alu_op_t alu_op,
  output rv_isa_pkg::alu_t    alu_ctrl,
  output logic                m_type,
  output logic                divide_instruction
);

  import rv_isa_pkg::*;

  // base integer op; alt selects SUB or SRA
  function automatic alu_t base_op(input fun3_t f3, input logic alt);
    unique case (f3)
      3'b000:           return alt ? SUB : ADD;
      3'b001:           return SLL;
      3'b010:           return SLT;
      3'b011:           return SLTU;
      3'b100:           return XOR;
      FUN3_SHIFT_RIGHT: return alt ? SRA : SRL;
      3'b110:           return OR;
      default:          return AND;
    endcase
  endfunction

  always_comb begin
    alu_ctrl = ADD;
    m_type = 1'b0;
    divide_instruction = 1'b0;
    unique case (alu_op)
      ALU_OP_ADD: alu_ctrl = ADD;
      ALU_OP_BRANCH: begin
        // compare by subtraction or set-less-than
        unique case (fun3)
          BLT, BGE:   alu_ctrl = SLT;
          BLTU, BGEU: alu_ctrl = SLTU;
          default:    alu_ctrl = SUB;
        endcase
      end
      ALU_OP_R: begin
        if (fun7 == FUN7_MULDIV) begin
          m_type = 1'b1;
          if (fun3[2]) begin
            divide_instruction = 1'b1;
            alu_ctrl = fun3[1] ? REM_OP : DIV_OP;
          end else begin
            unique case (fun3[1:0])
              2'b00:   alu_ctrl = MUL;
              2'b01:   alu_ctrl = MULH;
              2'b10:   alu_ctrl = MULHSU;
              default: alu_ctrl = MULHU;
            endcase
          end
        end else begin
          alu_ctrl = base_op(fun3, fun7[5]);
        end
      end
      default: begin
        // immediates have no SUB, only SRAI looks at fun7
        alu_ctrl = base_op(fun3, (fun3 == FUN3_SHIFT_RIGHT) && fun7[5]);
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/decode_control.sv
`timescale 1ns/1ps
`default_nettype none

module decode_control (
  input  logic                    clk,
  input  logic                    rst_n,
  input  rv_isa_pkg::opcode_t     opcode,
  input  logic                    clear_invalid,
  output pipe_ctrl_pkg::id_ctrl_t ctrl,
  output logic                    invalid_inst
);

  import rv_isa_pkg::*;
  import pipe_ctrl_pkg::*;

  logic illegal_opcode;

  always_comb begin
    ctrl = '0;
    ctrl.mem_to_reg = WB_ALU;
    ctrl.alu_op = ALU_OP_ADD;
    illegal_opcode = 1'b0;
    unique case (opcode)
      OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.lui = 1'b1;
      end
      OP_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.auipc = 1'b1;
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jump = 1'b1;
        ctrl.jal = 1'b1;
        ctrl.mem_to_reg = WB_PC4;
      end
      OP_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.jump = 1'b1;
        ctrl.mem_to_reg = WB_PC4;
        ctrl.use_rs1 = 1'b1;
      end
      OP_BRANCH: begin
        ctrl.branch = 1'b1;
        ctrl.alu_op = ALU_OP_BRANCH;
        ctrl.use_rs1 = 1'b1;
        ctrl.use_rs2 = 1'b1;
      end
      OP_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.mem_to_reg = WB_MEM;
        ctrl.use_rs1 = 1'b1;
      end
      OP_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.use_rs1 = 1'b1;
        ctrl.use_rs2 = 1'b1;
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_src = 1'b1;
        ctrl.alu_op = ALU_OP_I;
        ctrl.use_rs1 = 1'b1;
      end
      OP_REG: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op = ALU_OP_R;
        ctrl.use_rs1 = 1'b1;
        ctrl.use_rs2 = 1'b1;
      end
      OP_SYSTEM: begin
        ctrl.reg_write = 1'b1;
        ctrl.csr_type = 1'b1;
        ctrl.mem_to_reg = WB_CSR;
        ctrl.use_rs1 = 1'b1;
      end
      default: begin
        // unknown opcode behaves as a bubble
        ctrl = '0;
        illegal_opcode = 1'b1;
      end
    endcase
  end

  // sticky until a redirect, interrupt or mret
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      invalid_inst <= 1'b0;
    end else if (clear_invalid) begin
      invalid_inst <= 1'b0;
    end else if (illegal_opcode) begin
      invalid_inst <= 1'b1;
    end
  end

  a_no_write_conflict: assert property (@(posedge clk) disable iff (!rst_n)
    !(ctrl.reg_write && ctrl.mem_write));

endmodule

`default_nettype wire

// File: source/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

  // writeback source select
  typedef logic [1:0] wb_sel_t;
  localparam wb_sel_t WB_ALU = 2'd0;
  localparam wb_sel_t WB_MEM = 2'd1;
  localparam wb_sel_t WB_PC4 = 2'd2;
  localparam wb_sel_t WB_CSR = 2'd3;

  typedef struct packed {
    logic                 reg_write;
    logic                 mem_write;
    wb_sel_t              mem_to_reg;
    logic                 branch;
    logic                 alu_src;
    logic                 jump;
    logic                 lui;
    logic                 auipc;
    logic                 jal;
    rv_isa_pkg::alu_op_t  alu_op;
    logic                 csr_type;
    logic                 use_rs1;
    logic                 use_rs2;
  } id_ctrl_t;

  typedef logic [1:0] fwd_sel_t;
  localparam fwd_sel_t FWD_NONE = 2'd0;
  localparam fwd_sel_t FWD_WB   = 2'd1;
  localparam fwd_sel_t FWD_MEM  = 2'd2;

  typedef struct packed {
    logic     rd1_id;
    logic     rd2_id;
    fwd_sel_t rd1_exe;
    fwd_sel_t rd2_exe;
    logic     rd2_mem;
  } fwd_t;

  // pipeline register indices within en and clr
  localparam int NUM_STAGE_REGS = 4;
  localparam int IF_ID   = 0;
  localparam int ID_EXE  = 1;
  localparam int EXE_MEM = 2;

  typedef struct packed {
    logic                      pc_en;
    logic [NUM_STAGE_REGS-1:0] en;
    logic [NUM_STAGE_REGS-1:0] clr;
  } stage_ctrl_t;

endpackage

`default_nettype wire

// File: source/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  typedef logic [6:0] opcode_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [2:0] fun3_t;
  typedef logic [6:0] fun7_t;

  // ALU class passed from ID to EXE
  typedef logic [1:0] alu_op_t;
  localparam alu_op_t ALU_OP_ADD    = 2'b00;
  localparam alu_op_t ALU_OP_BRANCH = 2'b01;
  localparam alu_op_t ALU_OP_R      = 2'b10;
  localparam alu_op_t ALU_OP_I      = 2'b11;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA,
    OR, AND, MUL, MULH, MULHSU, MULHU, DIV_OP, REM_OP
  } alu_t;

  // funct3 of conditional branches
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  // M extension marker and the shared shift-right funct3
  localparam fun7_t FUN7_MULDIV      = 7'b0000001;
  localparam fun3_t FUN3_SHIFT_RIGHT = 3'b101;

endpackage

`default_nettype wire
